// ==== source/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] byte_enable_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    branch_none, branch_beq, branch_bne, branch_blt,
    branch_bge, branch_bltu, branch_bgeu
  } branch_op_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_sb, mem_sh, mem_sw
  } mem_op_e;

  // Standard RISC-V mcause codes
  typedef enum logic [3:0] {
    except_instr_misaligned = 4'd0,
    except_illegal_instr    = 4'd2,
    except_breakpoint       = 4'd3,
    except_load_misaligned  = 4'd4,
    except_store_misaligned = 4'd6,
    except_ecall_m          = 4'd11
  } ecause_e;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic ecall;
    logic ebreak;
    logic valid;
    logic jump;
    logic exception;
  } op_flags_t;

  localparam op_flags_t op_flags_none = '0;
  localparam word_t nop_instr = 32'h00000013;

  typedef struct packed {
    logic  done;
    word_t pc;
    word_t instr;
  } fetch_packet_t;

  typedef struct packed {
    op_flags_t  op;
    alu_op_e    alu_op;
    branch_op_e branch_op;
    mem_op_e    mem_op;
    word_t      imm;
  } decoder_result_t;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    word_t     wdata;
  } writeback_t;

  typedef struct packed {
    word_t        address;
    byte_enable_t byte_enable;
    logic         misaligned;
    ecause_e      ecause;
  } address_result_t;

  typedef struct packed {
    word_t      pc;
    word_t      npc;
    word_t      instr;
    reg_addr_t  waddr;
    reg_addr_t  raddr1;
    reg_addr_t  raddr2;
    word_t      imm;
    word_t      rdata1;
    word_t      rdata2;
    alu_op_e    alu_op;
    branch_op_e branch_op;
    mem_op_e    mem_op;
    op_flags_t  op;
    word_t      address;
    ecause_e    ecause;
    word_t      etval;
  } decoded_instr_t;

  typedef struct packed {
    logic         valid;
    word_t        addr;
    word_t        wdata;
    byte_enable_t wstrb;
  } mem_request_t;

endpackage

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  decode_pkg::word_t           instr,
  output decode_pkg::decoder_result_t result
);
  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    result = '0;
    result.op.valid = 1'b1;
    case (opcode)
      7'b0110111: begin
        result.op.lui = 1'b1;
        result.op.wren = 1'b1;
        result.imm = {instr[31:12], 12'b0};
      end
      7'b0010111: begin
        result.op.auipc = 1'b1;
        result.op.wren = 1'b1;
        result.imm = {instr[31:12], 12'b0};
      end
      7'b1101111: begin
        result.op.jal = 1'b1;
        result.op.wren = 1'b1;
        result.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      7'b1100111: begin
        result.op.jalr = 1'b1;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.valid = (funct3 == 3'b000);
        result.imm = {{20{instr[31]}}, instr[31:20]};
      end
      7'b1100011: begin
        result.op.branch = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        case (funct3)
          3'b000: result.branch_op = branch_beq;
          3'b001: result.branch_op = branch_bne;
          3'b100: result.branch_op = branch_blt;
          3'b101: result.branch_op = branch_bge;
          3'b110: result.branch_op = branch_bltu;
          3'b111: result.branch_op = branch_bgeu;
          default: result.op.valid = 1'b0;
        endcase
      end
      7'b0000011: begin
        result.op.load = 1'b1;
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.imm = {{20{instr[31]}}, instr[31:20]};
        case (funct3)
          3'b000: result.mem_op = mem_lb;
          3'b001: result.mem_op = mem_lh;
          3'b010: result.mem_op = mem_lw;
          3'b100: result.mem_op = mem_lbu;
          3'b101: result.mem_op = mem_lhu;
          default: result.op.valid = 1'b0;
        endcase
      end
      7'b0100011: begin
        result.op.store = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.rden2 = 1'b1;
        result.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        case (funct3)
          3'b000: result.mem_op = mem_sb;
          3'b001: result.mem_op = mem_sh;
          3'b010: result.mem_op = mem_sw;
          default: result.op.valid = 1'b0;
        endcase
      end
      7'b0010011, 7'b0110011: begin
        result.op.wren = 1'b1;
        result.op.rden1 = 1'b1;
        result.op.rden2 = opcode[5];
        result.imm = opcode[5] ? '0 : {{20{instr[31]}}, instr[31:20]};
        case (funct3)
          3'b000: result.alu_op = (opcode[5] && funct7[5]) ? alu_sub : alu_add;
          3'b001: result.alu_op = alu_sll;
          3'b010: result.alu_op = alu_slt;
          3'b011: result.alu_op = alu_sltu;
          3'b100: result.alu_op = alu_xor;
          3'b101: result.alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110: result.alu_op = alu_or;
          default: result.alu_op = alu_and;
        endcase
        // Immediate forms only constrain funct7 for shifts
        if (opcode[5] || funct3 == 3'b001 || funct3 == 3'b101) begin
          if (funct7 != 7'b0000000 &&
              !(funct7 == 7'b0100000 && (funct3 == 3'b101 || (opcode[5] && funct3 == 3'b000)))) begin
            result.op.valid = 1'b0;
          end
        end
      end
      7'b1110011: begin
        result.op.ecall = (instr == 32'h00000073);
        result.op.ebreak = (instr == 32'h00100073);
        result.op.valid = result.op.ecall | result.op.ebreak;
      end
      default: result.op.valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                   clock,
  input  logic                   reset,
  input  decode_pkg::reg_addr_t  raddr1,
  input  decode_pkg::reg_addr_t  raddr2,
  input  logic                   rden1,
  input  logic                   rden2,
  input  decode_pkg::writeback_t writeback,
  output decode_pkg::word_t      rdata1,
  output decode_pkg::word_t      rdata2
);
  import decode_pkg::*;

  word_t regs [32];

  function automatic word_t read_port(input reg_addr_t addr, input logic enable,
                                      input word_t stored, input writeback_t wb);
    if (!enable || addr == '0) begin
      return '0;
    end else if (wb.wren && wb.waddr == addr) begin
      return wb.wdata;
    end
    return stored;
  endfunction

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeback.wren && writeback.waddr != '0) begin
      regs[writeback.waddr] <= writeback.wdata;
    end
  end

  assign rdata1 = read_port(raddr1, rden1, regs[raddr1], writeback);
  assign rdata2 = read_port(raddr2, rden2, regs[raddr2], writeback);

  // x0 has to stay zero whatever the writeback stage sends
  assert property (@(posedge clock) disable iff (!reset) regs[0] == '0);

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input  decode_pkg::word_t      rdata1,
  input  decode_pkg::word_t      rdata2,
  input  decode_pkg::branch_op_e branch_op,
  output logic                   taken
);
  import decode_pkg::*;

  logic equal;
  logic less_signed;
  logic less_unsigned;

  assign equal = (rdata1 == rdata2);
  assign less_signed = ($signed(rdata1) < $signed(rdata2));
  assign less_unsigned = (rdata1 < rdata2);

  always_comb begin
    case (branch_op)
      branch_beq: taken = equal;
      branch_bne: taken = !equal;
      branch_blt: taken = less_signed;
      branch_bge: taken = !less_signed;
      branch_bltu: taken = less_unsigned;
      branch_bgeu: taken = !less_unsigned;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/address_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module address_unit (
  input  decode_pkg::word_t           pc,
  input  decode_pkg::word_t           rdata1,
  input  decode_pkg::word_t           imm,
  input  logic                        jal,
  input  logic                        jalr,
  input  logic                        branch,
  input  logic                        load,
  input  logic                        store,
  input  logic                        taken,
  input  decode_pkg::mem_op_e         mem_op,
  output decode_pkg::address_result_t result
);
  import decode_pkg::*;

  word_t address;

  always_comb begin
    if (jal || branch) begin
      address = pc + imm;
    end else if (jalr) begin
      address = (rdata1 + imm) & ~32'h1;
    end else begin
      address = rdata1 + imm;
    end

    result.address = address;
    result.misaligned = 1'b0;
    result.ecause = except_instr_misaligned;
    // A branch target only matters when the branch is taken
    if (jal || jalr || (branch && taken)) begin
      result.misaligned = address[1];
    end else if (load || store) begin
      case (mem_op)
        mem_lh, mem_lhu, mem_sh: result.misaligned = address[0];
        mem_lw, mem_sw: result.misaligned = |address[1:0];
        default: result.misaligned = 1'b0;
      endcase
      result.ecause = load ? except_load_misaligned : except_store_misaligned;
    end

    case (mem_op)
      mem_sb: result.byte_enable = 4'b0001 << address[1:0];
      mem_sh: result.byte_enable = 4'b0011 << address[1:0];
      mem_sw: result.byte_enable = 4'b1111;
      default: result.byte_enable = 4'b0000;
    endcase
  end

  always_comb begin
    assert #0 (!(load && store)) else $error("load and store flagged together");
  end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                        clock,
  input  logic                        reset,
  input  decode_pkg::fetch_packet_t   fetch,
  input  logic                        flush,
  input  logic                        hold,
  input  decode_pkg::decoder_result_t decoder_result,
  input  decode_pkg::word_t           rdata1,
  input  decode_pkg::word_t           rdata2,
  input  logic                        taken,
  input  decode_pkg::address_result_t address_result,
  output decode_pkg::word_t           instr,
  output decode_pkg::reg_addr_t       raddr1,
  output decode_pkg::reg_addr_t       raddr2,
  output logic                        rden1,
  output logic                        rden2,
  output decode_pkg::branch_op_e      branch_op,
  output decode_pkg::op_flags_t       unit_flags,
  output decode_pkg::word_t           imm,
  output decode_pkg::mem_op_e         mem_op,
  output decode_pkg::mem_request_t    mem_request,
  output decode_pkg::decoded_instr_t  decoded
);
  import decode_pkg::*;

  decoded_instr_t r;
  decoded_instr_t v;

  // An idle fetch decodes as a nop so the units see a harmless instruction
  assign instr = fetch.done ? fetch.instr : nop_instr;
  assign raddr1 = instr[19:15];
  assign raddr2 = instr[24:20];
  assign rden1 = decoder_result.op.rden1;
  assign rden2 = decoder_result.op.rden2;
  assign branch_op = decoder_result.branch_op;
  assign unit_flags = decoder_result.op;
  assign imm = decoder_result.imm;
  assign mem_op = decoder_result.mem_op;

  always_comb begin
    v = '0;
    v.pc = fetch.done ? fetch.pc : '0;
    v.instr = instr;
    v.npc = v.pc + 32'd4;
    v.waddr = instr[11:7];
    v.raddr1 = raddr1;
    v.raddr2 = raddr2;
    v.imm = decoder_result.imm;
    v.alu_op = decoder_result.alu_op;
    v.branch_op = decoder_result.branch_op;
    v.mem_op = decoder_result.mem_op;
    v.op = decoder_result.op;
    if (v.waddr == '0) begin
      v.op.wren = 1'b0;
    end
    v.rdata1 = rdata1;
    v.rdata2 = rdata2;
    v.op.jump = v.op.jal | v.op.jalr | taken;
    v.address = address_result.address;

    if (address_result.misaligned) begin
      v.op.exception = 1'b1;
      v.ecause = address_result.ecause;
      v.etval = address_result.address;
      if (v.op.load) begin
        v.op.load = 1'b0;
        v.op.wren = 1'b0;
      end else if (v.op.store) begin
        v.op.store = 1'b0;
      end else begin
        v.op.jump = 1'b0;
        v.op.wren = 1'b0;
      end
    end

    if (!v.op.valid) begin
      v.op.exception = 1'b1;
      v.ecause = except_illegal_instr;
      v.etval = v.instr;
    end else if (v.op.ebreak) begin
      v.op.exception = 1'b1;
      v.ecause = except_breakpoint;
      v.etval = v.instr;
    end else if (v.op.ecall) begin
      v.op.exception = 1'b1;
      v.ecause = except_ecall_m;
      v.etval = v.instr;
    end

    if (flush || hold || !fetch.done) begin
      v.op = op_flags_none;
    end

    mem_request.valid = v.op.load | v.op.store;
    mem_request.addr = v.address;
    case (v.mem_op)
      mem_sb: mem_request.wdata = {4{rdata2[7:0]}};
      mem_sh: mem_request.wdata = {2{rdata2[15:0]}};
      default: mem_request.wdata = rdata2;
    endcase
    mem_request.wstrb = v.op.load ? 4'b0000 : address_result.byte_enable;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= '0;
    end else begin
      r <= v;
    end
  end

  assign decoded = r;

  assert property (@(posedge clock) disable iff (!reset) !(decoded.op.load && decoded.op.store));

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  decode_pkg::fetch_packet_t  fetch,
  input  decode_pkg::writeback_t     writeback,
  input  logic                       flush,
  input  logic                       hold,
  output decode_pkg::decoded_instr_t decoded,
  output decode_pkg::mem_request_t   mem_request
);
  import decode_pkg::*;

  word_t           instr;
  decoder_result_t decoder_result;
  reg_addr_t       raddr1;
  reg_addr_t       raddr2;
  logic            rden1;
  logic            rden2;
  word_t           rdata1;
  word_t           rdata2;
  branch_op_e      branch_op;
  logic            taken;
  op_flags_t       unit_flags;
  word_t           imm;
  mem_op_e         mem_op;
  address_result_t address_result;

  instr_decoder i_instr_decoder (
    .instr  (instr),
    .result (decoder_result)
  );

  register_file i_register_file (
    .clock     (clock),
    .reset     (reset),
    .raddr1    (raddr1),
    .raddr2    (raddr2),
    .rden1     (rden1),
    .rden2     (rden2),
    .writeback (writeback),
    .rdata1    (rdata1),
    .rdata2    (rdata2)
  );

  branch_unit i_branch_unit (
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .branch_op (branch_op),
    .taken     (taken)
  );

  // An idle fetch decodes as a nop, which uses no pc-relative address
  address_unit i_address_unit (
    .pc     (fetch.pc),
    .rdata1 (rdata1),
    .imm    (imm),
    .jal    (unit_flags.jal),
    .jalr   (unit_flags.jalr),
    .branch (unit_flags.branch),
    .load   (unit_flags.load),
    .store  (unit_flags.store),
    .taken  (taken),
    .mem_op (mem_op),
    .result (address_result)
  );

  decode_stage i_decode_stage (
    .clock          (clock),
    .reset          (reset),
    .fetch          (fetch),
    .flush          (flush),
    .hold           (hold),
    .decoder_result (decoder_result),
    .rdata1         (rdata1),
    .rdata2         (rdata2),
    .taken          (taken),
    .address_result (address_result),
    .instr          (instr),
    .raddr1         (raddr1),
    .raddr2         (raddr2),
    .rden1          (rden1),
    .rden2          (rden2),
    .branch_op      (branch_op),
    .unit_flags     (unit_flags),
    .imm            (imm),
    .mem_op         (mem_op),
    .mem_request    (mem_request),
    .decoded        (decoded)
  );

endmodule

`default_nettype wire

// ==== tb/decode_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_unit_tb;
  import decode_pkg::*;

  localparam int test_cycles = 200;
  localparam int cycle_limit = 6 * test_cycles + 50;

  // Listed from entry 15 down to entry 0. Entries 0 to 9 are the RV32I opcodes the
  // stage accepts and entries 10 to 15 are encodings it has to reject
  localparam logic [15:0][6:0] opcode_table = {
    7'h0b, 7'h57, 7'h2b, 7'h7f, 7'h0f, 7'h00,
    7'h73, 7'h23, 7'h03, 7'h63, 7'h67, 7'h6f, 7'h33, 7'h13, 7'h17, 7'h37
  };

  logic           clock = 1'b0;
  logic           reset;
  fetch_packet_t  fetch;
  writeback_t     writeback;
  logic           flush;
  logic           hold;
  decoded_instr_t decoded;
  mem_request_t   mem_request;

  logic [15:0]    lfsr_state;
  word_t          shadow [32];
  decoded_instr_t expected_next;
  int             check_count = 0;
  int             error_count = 0;
  int             cycle_count;

  decode_unit i_decode_unit (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .writeback   (writeback),
    .flush       (flush),
    .hold        (hold),
    .decoded     (decoded),
    .mem_request (mem_request)
  );

  always #2 clock = ~clock;

  // Galois LFSR, one step per bit taken
  function automatic word_t random_bits(input int count);
    word_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  function automatic word_t make_instr(input int test);
    word_t ins;
    logic [3:0] index;
    logic [2:0] pick;
    logic [1:0] system_pick;
    ins = random_bits(32);
    pick = 3'(random_bits(3));
    case (test)
      1: index = 4'(pick[1:0]);
      2: index = 4'd2 + 4'(pick[0]);
      3: index = 4'd4 + ((pick[1:0] == 2'd3) ? 4'd2 : 4'(pick[1:0]));
      4: index = 4'd7 + 4'(pick[0]);
      5: begin
        case (pick)
          3'd0, 3'd1: index = 4'd9;
          3'd2: index = 4'd10;
          3'd3: index = 4'd11;
          3'd4: index = 4'd12;
          3'd5: index = 4'd5;
          3'd6: index = 4'd7;
          default: index = 4'd15;
        endcase
      end
      default: index = 4'(random_bits(4));
    endcase
    ins[6:0] = opcode_table[index];
    // Mostly legal funct7 values so that register forms decode as valid
    if ((test == 1 || test == 2) && random_bits(2) != 0) begin
      ins[31:25] = random_bits(1) ? 7'h00 : 7'h20;
    end
    // Few registers so that bypass hits and equal operands are common
    if (test == 2 || test == 3) begin
      ins[11:7] = 5'(random_bits(2));
      ins[19:15] = 5'(random_bits(2));
      ins[24:20] = 5'(random_bits(2));
    end
    if (test == 3 && index == 4'd5) begin
      ins[14:12] = 3'b000;
    end
    if (test == 5) begin
      system_pick = 2'(random_bits(2));
      if (index == 4'd9 && system_pick == 2'd0) begin
        ins = 32'h00000073;
      end else if (index == 4'd9 && system_pick == 2'd1) begin
        ins = 32'h00100073;
      end
      if (index == 4'd5) begin
        ins[12] = 1'b1;
      end
      if (index == 4'd7) begin
        ins[13:12] = 2'b11;
      end
    end
    return ins;
  endfunction

  function automatic word_t read_shadow(input reg_addr_t addr, input logic enable);
    if (!enable || addr == '0) begin
      return '0;
    end
    if (writeback.wren && writeback.waddr == addr) begin
      return writeback.wdata;
    end
    return shadow[addr];
  endfunction

  task automatic predict(output decoded_instr_t d, output mem_request_t m);
    word_t ins;
    word_t i_imm;
    word_t target;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic taken;
    logic misaligned;
    ecause_e cause;
    byte_enable_t strobe;
    ins = fetch.done ? fetch.instr : nop_instr;
    opc = ins[6:0];
    f3 = ins[14:12];
    f7 = ins[31:25];
    i_imm = {{20{ins[31]}}, ins[31:20]};
    d = '0;
    d.pc = fetch.done ? fetch.pc : '0;
    d.npc = d.pc + 32'd4;
    d.instr = ins;
    d.waddr = ins[11:7];
    d.raddr1 = ins[19:15];
    d.raddr2 = ins[24:20];
    d.op.valid = 1'b1;
    case (opc)
      7'h37, 7'h17: begin
        d.op.lui = opc[5];
        d.op.auipc = !opc[5];
        d.op.wren = 1'b1;
        d.imm = {ins[31:12], 12'b0};
      end
      7'h6f: begin
        d.op.jal = 1'b1;
        d.op.wren = 1'b1;
        d.imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'h67: begin
        d.op.jalr = 1'b1;
        d.op.wren = 1'b1;
        d.op.rden1 = 1'b1;
        d.op.valid = (f3 == 3'd0);
        d.imm = i_imm;
      end
      7'h63: begin
        d.op.branch = 1'b1;
        d.op.rden1 = 1'b1;
        d.op.rden2 = 1'b1;
        d.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        case (f3)
          3'd0: d.branch_op = branch_beq;
          3'd1: d.branch_op = branch_bne;
          3'd4: d.branch_op = branch_blt;
          3'd5: d.branch_op = branch_bge;
          3'd6: d.branch_op = branch_bltu;
          3'd7: d.branch_op = branch_bgeu;
          default: d.op.valid = 1'b0;
        endcase
      end
      7'h03: begin
        d.op.load = 1'b1;
        d.op.wren = 1'b1;
        d.op.rden1 = 1'b1;
        d.imm = i_imm;
        case (f3)
          3'd0: d.mem_op = mem_lb;
          3'd1: d.mem_op = mem_lh;
          3'd2: d.mem_op = mem_lw;
          3'd4: d.mem_op = mem_lbu;
          3'd5: d.mem_op = mem_lhu;
          default: d.op.valid = 1'b0;
        endcase
      end
      7'h23: begin
        d.op.store = 1'b1;
        d.op.rden1 = 1'b1;
        d.op.rden2 = 1'b1;
        d.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        case (f3)
          3'd0: d.mem_op = mem_sb;
          3'd1: d.mem_op = mem_sh;
          3'd2: d.mem_op = mem_sw;
          default: d.op.valid = 1'b0;
        endcase
      end
      7'h13, 7'h33: begin
        d.op.wren = 1'b1;
        d.op.rden1 = 1'b1;
        d.op.rden2 = opc[5];
        d.imm = opc[5] ? '0 : i_imm;
        case (f3)
          3'd0: d.alu_op = (opc[5] && f7[5]) ? alu_sub : alu_add;
          3'd1: d.alu_op = alu_sll;
          3'd2: d.alu_op = alu_slt;
          3'd3: d.alu_op = alu_sltu;
          3'd4: d.alu_op = alu_xor;
          3'd5: d.alu_op = f7[5] ? alu_sra : alu_srl;
          3'd6: d.alu_op = alu_or;
          default: d.alu_op = alu_and;
        endcase
        if (opc[5] || f3 == 3'd1 || f3 == 3'd5) begin
          if (!(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd5 || (opc[5] && f3 == 3'd0))))) begin
            d.op.valid = 1'b0;
          end
        end
      end
      7'h73: begin
        d.op.ecall = (ins == 32'h00000073);
        d.op.ebreak = (ins == 32'h00100073);
        d.op.valid = d.op.ecall | d.op.ebreak;
      end
      default: d.op.valid = 1'b0;
    endcase

    d.rdata1 = read_shadow(d.raddr1, d.op.rden1);
    d.rdata2 = read_shadow(d.raddr2, d.op.rden2);
    if (d.waddr == '0) begin
      d.op.wren = 1'b0;
    end
    case (d.branch_op)
      branch_beq: taken = (d.rdata1 == d.rdata2);
      branch_bne: taken = (d.rdata1 != d.rdata2);
      branch_blt: taken = ($signed(d.rdata1) < $signed(d.rdata2));
      branch_bge: taken = ($signed(d.rdata1) >= $signed(d.rdata2));
      branch_bltu: taken = (d.rdata1 < d.rdata2);
      branch_bgeu: taken = (d.rdata1 >= d.rdata2);
      default: taken = 1'b0;
    endcase
    d.op.jump = d.op.jal | d.op.jalr | taken;

    if (d.op.jal || d.op.branch) begin
      target = d.pc + d.imm;
    end else if (d.op.jalr) begin
      target = (d.rdata1 + d.imm) & ~32'h1;
    end else begin
      target = d.rdata1 + d.imm;
    end
    d.address = target;

    misaligned = 1'b0;
    cause = except_instr_misaligned;
    if (d.op.jal || d.op.jalr || (d.op.branch && taken)) begin
      misaligned = target[1];
    end else if (d.op.load || d.op.store) begin
      case (d.mem_op)
        mem_lh, mem_lhu, mem_sh: misaligned = target[0];
        mem_lw, mem_sw: misaligned = |target[1:0];
        default: misaligned = 1'b0;
      endcase
      cause = d.op.load ? except_load_misaligned : except_store_misaligned;
    end
    case (d.mem_op)
      mem_sb: strobe = 4'b0001 << target[1:0];
      mem_sh: strobe = 4'b0011 << target[1:0];
      mem_sw: strobe = 4'b1111;
      default: strobe = 4'b0000;
    endcase

    // Misalignment is overridden by illegal, then ebreak, then ecall
    if (misaligned) begin
      d.op.exception = 1'b1;
      d.ecause = cause;
      d.etval = target;
      if (d.op.load) begin
        d.op.load = 1'b0;
        d.op.wren = 1'b0;
      end else if (d.op.store) begin
        d.op.store = 1'b0;
      end else begin
        d.op.jump = 1'b0;
        d.op.wren = 1'b0;
      end
    end
    if (!d.op.valid || d.op.ebreak || d.op.ecall) begin
      d.op.exception = 1'b1;
      d.etval = ins;
      if (!d.op.valid) begin
        d.ecause = except_illegal_instr;
      end else if (d.op.ebreak) begin
        d.ecause = except_breakpoint;
      end else begin
        d.ecause = except_ecall_m;
      end
    end
    // An idle fetch carries no operation
    if (flush || hold || !fetch.done) begin
      d.op = op_flags_none;
    end

    m.valid = d.op.load | d.op.store;
    m.addr = target;
    case (d.mem_op)
      mem_sb: m.wdata = {4{d.rdata2[7:0]}};
      mem_sh: m.wdata = {2{d.rdata2[15:0]}};
      default: m.wdata = d.rdata2;
    endcase
    m.wstrb = d.op.load ? 4'b0000 : strobe;
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Checks the record from the last edge and the memory request of this cycle
  task automatic check_cycle();
    decoded_instr_t d;
    mem_request_t m;
    compare_value("decoded.pc", expected_next.pc, decoded.pc);
    compare_value("decoded.npc", expected_next.npc, decoded.npc);
    compare_value("decoded.instr", expected_next.instr, decoded.instr);
    compare_value("decoded.waddr", expected_next.waddr, decoded.waddr);
    compare_value("decoded.raddr1", expected_next.raddr1, decoded.raddr1);
    compare_value("decoded.raddr2", expected_next.raddr2, decoded.raddr2);
    compare_value("decoded.imm", expected_next.imm, decoded.imm);
    compare_value("decoded.rdata1", expected_next.rdata1, decoded.rdata1);
    compare_value("decoded.rdata2", expected_next.rdata2, decoded.rdata2);
    compare_value("decoded.alu_op", expected_next.alu_op, decoded.alu_op);
    compare_value("decoded.branch_op", expected_next.branch_op, decoded.branch_op);
    compare_value("decoded.mem_op", expected_next.mem_op, decoded.mem_op);
    compare_value("decoded.op", expected_next.op, decoded.op);
    compare_value("decoded.address", expected_next.address, decoded.address);
    compare_value("decoded.ecause", expected_next.ecause, decoded.ecause);
    compare_value("decoded.etval", expected_next.etval, decoded.etval);
    predict(d, m);
    compare_value("mem_request.valid", m.valid, mem_request.valid);
    if (m.valid) begin
      compare_value("mem_request.addr", m.addr, mem_request.addr);
      compare_value("mem_request.wdata", m.wdata, mem_request.wdata);
      compare_value("mem_request.wstrb", m.wstrb, mem_request.wstrb);
    end
    expected_next = d;
    if (writeback.wren && writeback.waddr != '0) begin
      shadow[writeback.waddr] = writeback.wdata;
    end
  endtask

  task automatic drive_inputs(input int test);
    fetch.done = (test == 6) ? (random_bits(2) != 0) : 1'b1;
    fetch.pc = random_bits(30) << 2;
    fetch.instr = make_instr(test);
    writeback.wren = 1'(random_bits(1));
    writeback.waddr = (test == 2 || test == 3) ? 5'(random_bits(2)) : 5'(random_bits(5));
    writeback.wdata = (test == 3 && random_bits(1) == 1) ? random_bits(2) : random_bits(32);
    flush = (test == 6) && (random_bits(2) == 0);
    hold = (test == 6) && (random_bits(2) == 0);
  endtask

  task automatic run_test(input int test, input string name);
    int checks_before;
    int errors_before;
    checks_before = check_count;
    errors_before = error_count;
    repeat (test_cycles) begin
      @(posedge clock);
      #0.5;
      drive_inputs(test);
      #2.5;
      check_cycle();
    end
    $display("Test %0d %s: %0d checks, %0d errors", test, name,
             check_count - checks_before, error_count - errors_before);
  endtask

  initial begin
    reset = 1'b0;
    fetch = '0;
    writeback = '0;
    flush = 1'b0;
    hold = 1'b0;
    lfsr_state = 16'd34144;
    expected_next = '0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (3) @(posedge clock);
    #0.5;
    reset = 1'b1;
    #2.5;
    check_cycle();
    run_test(1, "alu and immediate decode");
    run_test(2, "operand read with bypass");
    run_test(3, "branches and jumps");
    run_test(4, "loads and stores");
    run_test(5, "illegal, ecall and ebreak");
    run_test(6, "flush, hold and idle fetch");
    // One more edge so the last prediction is compared too
    @(posedge clock);
    #3;
    check_cycle();
    $display("Totals: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("The run timed out after %0d cycles", cycle_count);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== decode_unit.f ====
source/decode_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/branch_unit.sv
source/address_unit.sv
source/decode_stage.sv
source/decode_unit.sv
tb/decode_unit_tb.sv

// ==== Bender.yml ====
package:
  name: decode_unit

sources:
  - source/decode_pkg.sv
  - source/instr_decoder.sv
  - source/register_file.sv
  - source/branch_unit.sv
  - source/address_unit.sv
  - source/decode_stage.sv
  - source/decode_unit.sv
  - target: test
    files:
      - tb/decode_unit_tb.sv
